// File: verilog.f
+incdir+rtl
rtl/proc_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/regfile.sv
rtl/execute_unit.sv
rtl/writeback_unit.sv
rtl/proc_top.sv
bench/proc_checker.sv
bench/proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the processor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f verilog.f --top-module proc_tb -Mdir obj_dir -o proc_sim

./obj_dir/proc_sim | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: bench/proc_tb.sv
`timescale 1ns/10ps
`include "proc_params.svh"

module proc_tb
	import proc_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int HOLD_CYCLES = 60;
	localparam int NUM_ROWS = 12;
	localparam int NUM_RANDOM = 4;
	localparam int ROM_DEPTH = 16;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * HOLD_CYCLES + 200;
	localparam word_t NOP = 32'h0000_0013; // ADDI x0, x0, 0

	typedef struct packed {
		word_t in0;
		word_t in1;
		word_t in2;
		word_t exp0;
		word_t exp1;
		word_t exp2;
	} row_t;

	logic clk;
	logic rst;
	word_t imem_addr;
	word_t imem_data;
	word_t in0;
	word_t in1;
	word_t in2;
	word_t out0;
	word_t out1;
	word_t out2;
	logic check_req;
	int test_id;
	word_t exp0;
	word_t exp1;
	word_t exp2;
	int tests_run;
	int tests_failed;
	int errors;
	word_t rom [ROM_DEPTH];
	word_t rom_idx;
	row_t rows [NUM_ROWS];

	////////////////////////////////////////////////////////////
	// RV32 instruction encoders

	function automatic word_t alu_reg(logic [6:0] funct7, reg_addr_t rd, reg_addr_t rs1,
			reg_addr_t rs2);
		return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic word_t alu_imm(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, 7'b0010011};
	endfunction

	function automatic word_t branch_ne(reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t jump_link(reg_addr_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t csr_read(reg_addr_t rd, logic [11:0] csr);
		return {csr, 5'd0, 3'b010, rd, 7'b1110011}; // CSRRS rd, csr, x0
	endfunction

	function automatic word_t csr_write(logic [11:0] csr, reg_addr_t rs1);
		return {csr, rs1, 3'b001, 5'd0, 7'b1110011}; // CSRRW x0, csr, rs1
	endfunction

	// Outputs the program must reach for one set of inputs
	function automatic row_t make_row(word_t a, word_t b, word_t c);
		row_t row;
		row.in0 = a;
		row.in1 = b;
		row.in2 = c;
		row.exp0 = a + b;
		row.exp1 = a * b; // Low 32 bits
		row.exp2 = (a != b) ? c + 1 : c;
		return row;
	endfunction

	task automatic load_program();
		for (int i = 0; i < ROM_DEPTH; i++)
			rom[i] = NOP;
		rom[0] = csr_read(5'd3, `CSR_IN2);
		rom[1] = csr_read(5'd1, `CSR_IN0);
		rom[2] = csr_read(5'd2, `CSR_IN1); // ADD takes x2 from execute and x1 from writeback
		rom[3] = alu_reg(7'b0000000, 5'd4, 5'd1, 5'd2); // ADD x4, x1, x2
		rom[4] = alu_reg(7'b0000001, 5'd5, 5'd1, 5'd2); // MUL x5, x1, x2
		rom[5] = alu_imm(5'd6, 5'd3, 12'd1);
		rom[6] = alu_imm(5'd0, 5'd3, 12'd9); // Must leave x0 at zero
		rom[7] = branch_ne(5'd1, 5'd2, 13'd8); // Skips the next word
		rom[8] = alu_reg(7'b0000000, 5'd6, 5'd3, 5'd0); // x6 = x3, reads x0 right after its write
		rom[9] = csr_write(`CSR_OUT0, 5'd4);
		rom[10] = csr_write(`CSR_OUT1, 5'd5);
		rom[11] = csr_write(`CSR_OUT2, 5'd6);
		rom[12] = jump_link(5'd7, -21'sd48); // Back to address 0
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		rows[0] = make_row(32'd5, 32'd7, 32'd100);
		rows[1] = make_row(32'd9, 32'd9, 32'd20);
		rows[2] = make_row(32'd0, 32'd0, 32'd0);
		rows[3] = make_row(32'd0, 32'd123, 32'hFFFF_FFFF);
		rows[4] = make_row(32'hFFFF_FFFD, 32'd4, 32'hFFFF_FFF6);
		rows[5] = make_row(32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'd7);
		rows[6] = make_row(32'h8000_0000, 32'd2, 32'h7FFF_FFFF);
		rows[7] = make_row(32'h0001_0000, 32'h0001_0000, 32'h1234_5678);
		for (int i = 0; i < NUM_RANDOM; i++) begin
			a = $urandom();
			b = (i == NUM_RANDOM - 1) ? a : $urandom(); // Last one is an equal pair
			rows[NUM_ROWS - NUM_RANDOM + i] = make_row(a, b, $urandom());
		end
	endtask

	// Instruction memory answers in the same cycle
	assign rom_idx = imem_addr / `PC_STEP;

	always_comb begin
		if (rom_idx < ROM_DEPTH)
			imem_data = rom[rom_idx[3:0]];
		else
			imem_data = NOP;
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	proc_top proc_top_i (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.in0(in0),
		.in1(in1),
		.in2(in2),
		.out0(out0),
		.out1(out1),
		.out2(out2)
	);

	proc_checker proc_checker_i (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.out0(out0),
		.out1(out1),
		.out2(out2),
		.check_req(check_req),
		.test_id(test_id),
		.exp0(exp0),
		.exp1(exp1),
		.exp2(exp2),
		.tests_run(tests_run),
		.tests_failed(tests_failed),
		.errors(errors)
	);

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		void'($urandom(28));
		rst = 1'b1;
		in0 = '0;
		in1 = '0;
		in2 = '0;
		check_req = 1'b0;
		test_id = 0;
		exp0 = '0;
		exp1 = '0;
		exp2 = '0;
		load_program();
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			@(posedge clk);
			check_req <= 1'b0;
			test_id <= r + 1;
			in0 <= rows[r].in0;
			in1 <= rows[r].in1;
			in2 <= rows[r].in2;
			exp0 <= rows[r].exp0;
			exp1 <= rows[r].exp1;
			exp2 <= rows[r].exp2;
			repeat (HOLD_CYCLES - 1) @(posedge clk);
			check_req <= 1'b1; // Seen by the checker half a cycle later
		end
		@(posedge clk);
		check_req <= 1'b0;
		@(posedge clk);
		$display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
			errors);
		if (tests_failed == 0 && errors == 0 && tests_run == NUM_ROWS + 1)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		#((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: bench/proc_checker.sv
`timescale 1ns/10ps
`include "proc_params.svh"

module proc_checker
	import proc_pkg::*;
(
	input logic clk,
	input logic rst,
	input word_t imem_addr,
	input word_t out0,
	input word_t out1,
	input word_t out2,
	input logic check_req,
	input int test_id,
	input word_t exp0,
	input word_t exp1,
	input word_t exp2,
	output int tests_run,
	output int tests_failed,
	output int errors
);

	int run_count = 0;
	int fail_count = 0;
	int err_count = 0;
	int test_errs = 0;
	logic in_reset = 1'b0;
	logic saw_start = 1'b0; // PC was back at the first instruction during this row

	assign tests_run = run_count;
	assign tests_failed = fail_count;
	assign errors = err_count;

	task automatic compare_word(string name, word_t got, word_t want);
		if (got !== want) begin
			$display("ERROR at %0d ns: %s expected %h, got %h", $time, name, want, got);
			err_count++;
			test_errs++;
		end
	endtask

	task automatic close_test(string label);
		run_count++;
		if (test_errs == 0) begin
			$display("test %0d (%s): passed", test_id, label);
		end else begin
			fail_count++;
			$display("test %0d (%s): failed with %0d errors", test_id, label, test_errs);
		end
		test_errs = 0;
	endtask

	// Sampling on the falling edge keeps half a cycle between input changes and outputs
	always @(negedge clk) begin
		if (rst) begin
			in_reset = 1'b1;
			saw_start = 1'b0;
		end else begin
			if (in_reset) begin
				compare_word("imem_addr", imem_addr, `RESET_PC);
				compare_word("out0", out0, '0);
				compare_word("out1", out1, '0);
				compare_word("out2", out2, '0);
				close_test("reset state");
			end else if (imem_addr == `RESET_PC)
				saw_start = 1'b1; // Only a jump back counts, not the reset PC
			in_reset = 1'b0;
			if (check_req) begin
				compare_word("out0", out0, exp0);
				compare_word("out1", out1, exp1);
				compare_word("out2", out2, exp2);
				if (!saw_start) begin
					$display("The program never jumped back to its start during row %0d", test_id);
					err_count++;
					test_errs++;
				end
				saw_start = 1'b0;
				close_test($sformatf("row %0d", test_id));
			end
		end
	end

endmodule

// File: rtl/proc_top.sv
`timescale 1ns/10ps

module proc_top
	import proc_pkg::*;
(
	input logic clk,
	input logic rst,
	output word_t imem_addr,
	input word_t imem_data,
	input word_t in0,
	input word_t in1,
	input word_t in2,
	output word_t out0,
	output word_t out1,
	output word_t out2
);

	fd_t fd;
	dx_t dx;
	xw_t xw;
	wb_t rf_wr;
	byp_t byp_x;
	byp_t byp_w;
	logic br_taken;
	word_t br_target;
	logic jump_valid;
	word_t jump_target;
	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t rs1_data;
	word_t rs2_data;

	fetch_unit fetch_unit_i (
		.clk(clk),
		.rst(rst),
		.br_taken(br_taken),
		.br_target(br_target),
		.jump_valid(jump_valid),
		.jump_target(jump_target),
		.imem_data(imem_data),
		.imem_addr(imem_addr),
		.fd(fd)
	);

	decode_unit decode_unit_i (
		.clk(clk),
		.rst(rst),
		.fd(fd),
		.br_taken(br_taken),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.byp_x(byp_x),
		.byp_w(byp_w),
		.jump_valid(jump_valid),
		.jump_target(jump_target),
		.dx(dx)
	);

	regfile regfile_i (
		.clk(clk),
		.wr(rf_wr),
		.raddr0(rs1_addr),
		.raddr1(rs2_addr),
		.rdata0(rs1_data),
		.rdata1(rs2_data)
	);

	execute_unit execute_unit_i (
		.clk(clk),
		.rst(rst),
		.dx(dx),
		.in0(in0),
		.in1(in1),
		.in2(in2),
		.br_taken(br_taken),
		.br_target(br_target),
		.byp_x(byp_x),
		.xw(xw)
	);

	writeback_unit writeback_unit_i (
		.clk(clk),
		.rst(rst),
		.xw(xw),
		.rf_wr(rf_wr),
		.byp_w(byp_w),
		.out0(out0),
		.out1(out1),
		.out2(out2)
	);

endmodule

// File: rtl/writeback_unit.sv
`timescale 1ns/10ps

module writeback_unit
	import proc_pkg::*;
(
	input logic clk,
	input logic rst,
	input xw_t xw,
	output wb_t rf_wr,
	output byp_t byp_w,
	output word_t out0,
	output word_t out1,
	output word_t out2
);

	word_t out_r [3];

	assign rf_wr.wen = xw.valid && xw.rf_wen;
	assign rf_wr.waddr = xw.rd;
	assign rf_wr.wdata = xw.result;

	// Same value the register file takes at the next edge
	assign byp_w.valid_wen = rf_wr.wen;
	assign byp_w.rd = rf_wr.waddr;
	assign byp_w.value = rf_wr.wdata;

	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (rst)
				out_r[i] <= '0;
			else if (xw.valid && xw.out_sel[i])
				out_r[i] <= xw.csr_data;
		end
	end

	assign out0 = out_r[0];
	assign out1 = out_r[1];
	assign out2 = out_r[2];

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/10ps

module execute_unit
	import proc_pkg::*;
(
	input logic clk,
	input logic rst,
	input dx_t dx,
	input word_t in0,
	input word_t in1,
	input word_t in2,
	output logic br_taken,
	output word_t br_target,
	output byp_t byp_x,
	output xw_t xw
);

	word_t sum;
	word_t prod;
	word_t csr_in;
	word_t result;
	res_sel_e res_sel;

	assign sum = dx.op1 + dx.op2;
	assign prod = dx.op1 * dx.op2; // Low half only

	always_comb begin
		case (dx.csr_sel)
			2'd0: csr_in = in0;
			2'd1: csr_in = in1;
			2'd2: csr_in = in2;
			default: csr_in = '0;
		endcase
	end

	always_comb begin
		case (dx.op)
			OP_MUL: res_sel = RES_PROD;
			OP_CSRR: res_sel = RES_CSR;
			default: res_sel = RES_SUM; // ADD, ADDI and the JAL link
		endcase
	end

	always_comb begin
		case (res_sel)
			RES_PROD: result = prod;
			RES_CSR: result = csr_in;
			default: result = sum;
		endcase
	end

	assign br_taken = dx.valid && dx.op == OP_BNE && dx.op1 != dx.op2;
	assign br_target = dx.br_target;

	assign byp_x.valid_wen = dx.valid && dx.rf_wen;
	assign byp_x.rd = dx.rd;
	assign byp_x.value = result;

	always_ff @(posedge clk) begin
		if (rst) begin
			xw.valid <= 1'b0;
		end else begin
			xw.valid <= dx.valid;
			xw.rd <= dx.rd;
			xw.rf_wen <= dx.rf_wen;
			xw.result <= result;
			xw.csr_data <= dx.csr_data;
			xw.out_sel <= dx.out_sel;
		end
	end

	// Two output registers must never load from one CSRW
	out_sel_onehot_a: assert property (@(posedge clk) disable iff (rst)
		dx.valid |-> $onehot0(dx.out_sel))
		else $error("Output select not one-hot: %b", dx.out_sel);

endmodule

// File: rtl/regfile.sv
`timescale 1ns/10ps
`include "proc_params.svh"

module regfile
	import proc_pkg::*;
(
	input logic clk,
	input wb_t wr,
	input reg_addr_t raddr0,
	input reg_addr_t raddr1,
	output word_t rdata0,
	output word_t rdata1
);

	word_t regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (wr.wen && wr.waddr != '0) // x0 stays zero
			regs[wr.waddr] <= wr.wdata;
	end

	// Reads do not see a write in the same cycle
	assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: rtl/decode_unit.sv
`timescale 1ns/10ps
`include "proc_params.svh"

module decode_unit
	import proc_pkg::*;
(
	input logic clk,
	input logic rst,
	input fd_t fd,
	input logic br_taken,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	input word_t rs1_data,
	input word_t rs2_data,
	input byp_t byp_x,
	input byp_t byp_w,
	output logic jump_valid,
	output word_t jump_target,
	output dx_t dx
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [11:0] csr_num;
	op_e dec_op;
	logic dec_rf_wen;
	logic [1:0] dec_csr_sel;
	logic [2:0] dec_out_sel;
	word_t imm_i;
	word_t imm_b;
	word_t imm_j;
	word_t pc_target;
	word_t rs1_val;
	word_t rs2_val;
	dx_t dx_next;

	// Youngest producer wins and x0 is never forwarded
	function automatic word_t bypass(reg_addr_t addr, word_t rf_val, byp_t bx, byp_t bw);
		word_t val;
		if (addr != '0 && bx.valid_wen && bx.rd == addr)
			val = bx.value;
		else if (addr != '0 && bw.valid_wen && bw.rd == addr)
			val = bw.value;
		else
			val = rf_val;
		return val;
	endfunction

	assign opcode = fd.inst[6:0];
	assign funct3 = fd.inst[14:12];
	assign funct7 = fd.inst[31:25];
	assign csr_num = fd.inst[31:20];
	assign rs1_addr = fd.inst[19:15];
	assign rs2_addr = fd.inst[24:20];

	////////////////////////////////////////////////////////////
	// Instruction match

	always_comb begin
		dec_op = OP_NONE;
		dec_csr_sel = 2'd0;
		dec_out_sel = 3'b000;
		case (opcode)
			7'b0110011: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000)
					dec_op = OP_ADD;
				else if (funct3 == 3'b000 && funct7 == 7'b0000001)
					dec_op = OP_MUL;
			end
			7'b0010011: if (funct3 == 3'b000) dec_op = OP_ADDI;
			7'b1100011: if (funct3 == 3'b001) dec_op = OP_BNE;
			7'b1101111: dec_op = OP_JAL;
			7'b1110011: begin
				if (funct3 == 3'b010) begin
					dec_op = OP_CSRR;
					case (csr_num)
						`CSR_IN0: dec_csr_sel = 2'd0;
						`CSR_IN1: dec_csr_sel = 2'd1;
						`CSR_IN2: dec_csr_sel = 2'd2;
						default: dec_op = OP_NONE; // Unknown CSR
					endcase
				end else if (funct3 == 3'b001) begin
					dec_op = OP_CSRW;
					case (csr_num)
						`CSR_OUT0: dec_out_sel = 3'b001;
						`CSR_OUT1: dec_out_sel = 3'b010;
						`CSR_OUT2: dec_out_sel = 3'b100;
						default: dec_op = OP_NONE;
					endcase
				end
			end
			default: dec_op = OP_NONE;
		endcase
		dec_rf_wen = dec_op inside {OP_ADD, OP_ADDI, OP_MUL, OP_JAL, OP_CSRR};
	end

	////////////////////////////////////////////////////////////
	// Immediates, targets and operands

	assign imm_i = {{20{fd.inst[31]}}, fd.inst[31:20]};
	assign imm_b = {{20{fd.inst[31]}}, fd.inst[7], fd.inst[30:25], fd.inst[11:8], 1'b0};
	assign imm_j = {{12{fd.inst[31]}}, fd.inst[19:12], fd.inst[20], fd.inst[30:21], 1'b0};

	// One adder serves both the jump and the branch target
	assign pc_target = fd.pc + ((dec_op == OP_JAL) ? imm_j : imm_b);

	assign rs1_val = bypass(rs1_addr, rs1_data, byp_x, byp_w);
	assign rs2_val = bypass(rs2_addr, rs2_data, byp_x, byp_w);

	assign jump_valid = fd.valid && dec_op == OP_JAL;
	assign jump_target = pc_target;

	always_comb begin
		dx_next.valid = fd.valid && !br_taken; // Squashed behind a taken branch
		dx_next.op = dec_op;
		dx_next.rd = fd.inst[11:7];
		dx_next.rf_wen = dec_rf_wen;
		dx_next.op1 = (dec_op == OP_JAL) ? fd.pc : rs1_val; // JAL links pc plus one step
		case (dec_op)
			OP_ADDI: dx_next.op2 = imm_i;
			OP_JAL: dx_next.op2 = `PC_STEP;
			default: dx_next.op2 = rs2_val;
		endcase
		dx_next.csr_data = rs1_val;
		dx_next.csr_sel = dec_csr_sel;
		dx_next.out_sel = dec_out_sel;
		dx_next.br_target = pc_target;
	end

	always_ff @(posedge clk) begin
		if (rst)
			dx.valid <= 1'b0;
		else
			dx <= dx_next;
	end

	// The word fetched behind a jump never reaches decode
	jump_squash_a: assert property (@(posedge clk) disable iff (rst)
		jump_valid |=> !fd.valid)
		else $error("Instruction behind a jump was not squashed");

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps
`include "proc_params.svh"

module fetch_unit
	import proc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic br_taken,
	input word_t br_target,
	input logic jump_valid,
	input word_t jump_target,
	input word_t imem_data,
	output word_t imem_addr,
	output fd_t fd
);

	word_t pc;
	word_t pc_next;

	// A taken branch in execute is older than a jump in decode
	always_comb begin
		if (br_taken)
			pc_next = br_target;
		else if (jump_valid)
			pc_next = jump_target;
		else
			pc_next = pc + `PC_STEP;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc <= `RESET_PC;
		else
			pc <= pc_next;
	end

	assign imem_addr = pc; // Memory answers in the same cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			fd.valid <= 1'b0;
		end else begin
			fd.valid <= !(br_taken || jump_valid); // Drop the word fetched down the wrong path
			fd.inst <= imem_data;
			fd.pc <= pc;
		end
	end

	// Targets come from decode and execute, so misaligned immediates would show here
	pc_aligned_a: assert property (@(posedge clk) disable iff (rst)
		(pc % `PC_STEP) == 0)
		else $error("PC not aligned: %h", pc);

endmodule

// File: rtl/proc_pkg.sv
`include "proc_params.svh"

package proc_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_ADDI,
		OP_MUL,
		OP_BNE,
		OP_JAL,
		OP_CSRR,
		OP_CSRW,
		OP_NONE
	} op_e;

	typedef enum logic [1:0] {
		RES_SUM,
		RES_PROD,
		RES_CSR
	} res_sel_e;

	////////////////////////////////////////////////////////////
	// Stage registers

	typedef struct packed {
		logic valid;
		word_t inst;
		word_t pc;
	} fd_t;

	typedef struct packed {
		logic valid;
		op_e op;
		reg_addr_t rd;
		logic rf_wen;
		word_t op1; // Operands after bypass and immediate
		word_t op2;
		word_t csr_data; // rs1 value for CSRW
		logic [1:0] csr_sel;
		logic [2:0] out_sel; // One-hot output CSR
		word_t br_target;
	} dx_t;

	typedef struct packed {
		logic valid;
		reg_addr_t rd;
		logic rf_wen;
		word_t result;
		word_t csr_data;
		logic [2:0] out_sel;
	} xw_t;

	typedef struct packed {
		logic wen;
		reg_addr_t waddr;
		word_t wdata;
	} wb_t;

	typedef struct packed {
		logic valid_wen;
		reg_addr_t rd;
		word_t value;
	} byp_t;

endpackage

// File: rtl/proc_params.svh
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Datapath and register file sizes
`define XLEN 32
`define REG_ADDR_W 5
`define NUM_REGS 32

`define RESET_PC 32'h0000_0000
`define PC_STEP 32'd4 // Every instruction is one word

////////////////////////////////////////////////////////////
// CSR numbers

// Input words, read by CSRR
`define CSR_IN0 12'hFC2
`define CSR_IN1 12'hFC3
`define CSR_IN2 12'hFC4

// Output words, written by CSRW
`define CSR_OUT0 12'h7C2
`define CSR_OUT1 12'h7C3
`define CSR_OUT2 12'h7C4

`endif
